/* include/bwt_queue_cfg.svh */
// sizing and field widths shared by the forward read queue blocks
`ifndef BWT_QUEUE_CFG_SVH
`define BWT_QUEUE_CFG_SVH

// ====================
// queue sizing
`define MAX_READ 64
`define READ_NUM_WIDTH 6
`define READ_QUEUE_DEPTH (2 * `MAX_READ)  // two slots per read in flight
`define READ_PTR_WIDTH 7
`define OCC_DEPTH `MAX_READ
`define OCC_PTR_WIDTH 6

// ====================
// item field widths
`define POS_WIDTH 7
`define STATUS_WIDTH 6
`define BASE_WIDTH 8
`define IK_WIDTH 64
`define IK_KEPT_WIDTH 33  // low bits of each interval word
`define INFO_SLICE_WIDTH 7
`define INFO_HI_LSB 32  // upper info slice sits at 38..32
`define CNT_WIDTH 32

`endif

/* src/queue_status_pkg.sv */
// status codes of forward pipeline items and the stored-status test
`default_nettype none
`include "bwt_queue_cfg.svh"

package queue_status_pkg;

	localparam logic [`STATUS_WIDTH-1:0] F_INIT = 0;  // first round of a new read
	localparam logic [`STATUS_WIDTH-1:0] F_RUN = 1;  // waits on an occ response
	localparam logic [`STATUS_WIDTH-1:0] F_BREAK = 2;  // leaves without a response
	localparam logic [`STATUS_WIDTH-1:0] ST_BUBBLE = 6'b110000;

	// only real forward items enter the read queue
	function automatic logic is_stored_status(input logic [`STATUS_WIDTH-1:0] s);
		return (s == F_INIT) || (s == F_RUN) || (s == F_BREAK);
	endfunction

endpackage

`default_nettype wire

/* src/queue_entry_pkg.sv */
// bit layout of one forward entry held in the read queue
`default_nettype none
`include "bwt_queue_cfg.svh"

package queue_entry_pkg;

	// ====================
	// field offsets, lowest field first
	localparam int OFS_STATUS = 0;
	localparam int OFS_BACKWARD_X = OFS_STATUS + `STATUS_WIDTH;
	localparam int OFS_QUERY = OFS_BACKWARD_X + `POS_WIDTH;
	localparam int OFS_MIN_INTV = OFS_QUERY + `BASE_WIDTH;
	localparam int OFS_FORWARD_I = OFS_MIN_INTV + `POS_WIDTH;
	localparam int OFS_INFO_LO = OFS_FORWARD_I + `POS_WIDTH;
	localparam int OFS_INFO_HI = OFS_INFO_LO + `INFO_SLICE_WIDTH;
	localparam int OFS_IK_X2 = OFS_INFO_HI + `INFO_SLICE_WIDTH;
	localparam int OFS_IK_X1 = OFS_IK_X2 + `IK_KEPT_WIDTH;
	localparam int OFS_IK_X0 = OFS_IK_X1 + `IK_KEPT_WIDTH;
	localparam int OFS_READ_NUM = OFS_IK_X0 + `IK_KEPT_WIDTH;
	localparam int OFS_PTR_CURR = OFS_READ_NUM + `READ_NUM_WIDTH;

	// 161 bits in total
	localparam int ENTRY_WIDTH = OFS_PTR_CURR + `POS_WIDTH;

endpackage

`default_nettype wire

/* src/query_delay_line.sv */
// stall-gated delay line that waits for the query base and packs queue entries
`timescale 1ns/1ps
`default_nettype none
`include "bwt_queue_cfg.svh"

module query_delay_line
	import queue_entry_pkg::*;
	import queue_status_pkg::*;
(
	input wire Clk_32UI,
	input wire stall,
	input wire [`STATUS_WIDTH-1:0] status,
	input wire [`POS_WIDTH-1:0] ptr_curr,
	input wire [`READ_NUM_WIDTH-1:0] read_num,
	input wire [`IK_WIDTH-1:0] ik_x0,
	input wire [`IK_WIDTH-1:0] ik_x1,
	input wire [`IK_WIDTH-1:0] ik_x2,
	input wire [`IK_WIDTH-1:0] ik_info,
	input wire [`POS_WIDTH-1:0] forward_i,
	input wire [`POS_WIDTH-1:0] min_intv,
	input wire [`POS_WIDTH-1:0] backward_x,
	input wire [`BASE_WIDTH-1:0] new_read_query_2Queue,
	output logic [ENTRY_WIDTH-1:0] entry,
	output wire entry_write
);

	localparam int STAGE_WIDTH = `STATUS_WIDTH + `READ_NUM_WIDTH + 4 * `IK_WIDTH
		+ 4 * `POS_WIDTH;

	logic [STAGE_WIDTH-1:0] in_word;
	logic [STAGE_WIDTH-1:0] stage [3];  // three cycles for the read RAM

	// stage 2 fields
	logic [`STATUS_WIDTH-1:0] s2_status;
	logic [`POS_WIDTH-1:0] s2_ptr_curr, s2_forward_i, s2_min_intv, s2_backward_x;
	logic [`READ_NUM_WIDTH-1:0] s2_read_num;
	logic [`IK_WIDTH-1:0] s2_ik_x0, s2_ik_x1, s2_ik_x2, s2_ik_info;

	assign in_word = {status, ptr_curr, read_num, ik_x0, ik_x1, ik_x2, ik_info,
		forward_i, min_intv, backward_x};

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			stage[0] <= in_word;
			stage[1] <= stage[0];
			stage[2] <= stage[1];
		end
	end

	assign {s2_status, s2_ptr_curr, s2_read_num, s2_ik_x0, s2_ik_x1, s2_ik_x2, s2_ik_info,
		s2_forward_i, s2_min_intv, s2_backward_x} = stage[2];

	// ====================
	// packing register, query base lands here
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			entry[OFS_STATUS +: `STATUS_WIDTH] <= s2_status;
			entry[OFS_BACKWARD_X +: `POS_WIDTH] <= s2_backward_x;
			entry[OFS_QUERY +: `BASE_WIDTH] <= new_read_query_2Queue;
			entry[OFS_MIN_INTV +: `POS_WIDTH] <= s2_min_intv;
			entry[OFS_FORWARD_I +: `POS_WIDTH] <= s2_forward_i;
			entry[OFS_INFO_LO +: `INFO_SLICE_WIDTH] <= s2_ik_info[0 +: `INFO_SLICE_WIDTH];
			entry[OFS_INFO_HI +: `INFO_SLICE_WIDTH] <= s2_ik_info[`INFO_HI_LSB +: `INFO_SLICE_WIDTH];
			entry[OFS_IK_X2 +: `IK_KEPT_WIDTH] <= s2_ik_x2[`IK_KEPT_WIDTH-1:0];
			entry[OFS_IK_X1 +: `IK_KEPT_WIDTH] <= s2_ik_x1[`IK_KEPT_WIDTH-1:0];
			entry[OFS_IK_X0 +: `IK_KEPT_WIDTH] <= s2_ik_x0[`IK_KEPT_WIDTH-1:0];
			entry[OFS_READ_NUM +: `READ_NUM_WIDTH] <= s2_read_num;
			entry[OFS_PTR_CURR +: `POS_WIDTH] <= s2_ptr_curr;
		end
	end

	// bubbles never reach the queue
	assign entry_write = is_stored_status(entry[OFS_STATUS +: `STATUS_WIDTH]) && !stall;

endmodule

`default_nettype wire

/* src/read_queue.sv */
// circular read queue holding packed forward entries until dispatch
`timescale 1ns/1ps
`default_nettype none
`include "bwt_queue_cfg.svh"

module read_queue
	import queue_entry_pkg::*;
(
	input wire Clk_32UI,
	input wire reset_n,
	input wire [ENTRY_WIDTH-1:0] entry,
	input wire entry_write,
	input wire pop,
	output wire [ENTRY_WIDTH-1:0] head_entry,
	output wire head_valid
);

	logic [ENTRY_WIDTH-1:0] mem [`READ_QUEUE_DEPTH];
	logic [`READ_PTR_WIDTH-1:0] wr_ptr;
	logic [`READ_PTR_WIDTH-1:0] rd_ptr;

	// ====================
	// storage
	always_ff @(posedge Clk_32UI) begin
		if (entry_write) begin
			mem[wr_ptr] <= entry;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (entry_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// ====================
	// head seen without delay
	assign head_entry = mem[rd_ptr];
	assign head_valid = (wr_ptr != rd_ptr);  // never full, producer keeps in flight low

endmodule

`default_nettype wire

/* src/occ_buffer.sv */
// FIFO of DRAM occupancy responses with registered count outputs
`timescale 1ns/1ps
`default_nettype none
`include "bwt_queue_cfg.svh"

module occ_buffer (
	input wire Clk_32UI,
	input wire reset_n,
	input wire DRAM_get,
	input wire [`CNT_WIDTH-1:0] cnt_a0, cnt_a1, cnt_a2, cnt_a3,
	input wire [`CNT_WIDTH-1:0] cntl_a0, cntl_a1, cntl_a2, cntl_a3,
	input wire occ_pop,
	output wire occ_valid,
	output logic [`CNT_WIDTH-1:0] cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out,
	output logic [`CNT_WIDTH-1:0] cntl_a0_out, cntl_a1_out, cntl_a2_out, cntl_a3_out
);

	logic [8*`CNT_WIDTH-1:0] mem [`OCC_DEPTH];
	logic [`OCC_PTR_WIDTH-1:0] wr_ptr;
	logic [`OCC_PTR_WIDTH-1:0] rd_ptr;

	// DRAM writes ignore stall
	always_ff @(posedge Clk_32UI) begin
		if (DRAM_get) begin
			mem[wr_ptr] <= {cnt_a0, cnt_a1, cnt_a2, cnt_a3, cntl_a0, cntl_a1, cntl_a2, cntl_a3};
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (DRAM_get) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (occ_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// ====================
	// head slot registered, lines up with the popped item on status_out
	always_ff @(posedge Clk_32UI) begin
		if (reset_n) begin
			{cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out,
				cntl_a0_out, cntl_a1_out, cntl_a2_out, cntl_a3_out} <= mem[rd_ptr];
		end
	end

	assign occ_valid = (wr_ptr != rd_ptr);

endmodule

`default_nettype wire

/* src/queue_dispatch.sv */
// pop arbiter choosing break, paired, new read or bubble for the forward outputs
`timescale 1ns/1ps
`default_nettype none
`include "bwt_queue_cfg.svh"

module queue_dispatch
	import queue_entry_pkg::*;
	import queue_status_pkg::*;
(
	input wire Clk_32UI,
	input wire reset_n,
	input wire stall,
	input wire [ENTRY_WIDTH-1:0] head_entry,
	input wire head_valid,
	input wire occ_valid,
	input wire new_read_valid,
	input wire [`READ_NUM_WIDTH-1:0] new_read_num,
	input wire [`IK_WIDTH-1:0] new_ik_x0,
	input wire [`IK_WIDTH-1:0] new_ik_x1,
	input wire [`IK_WIDTH-1:0] new_ik_x2,
	input wire [`IK_WIDTH-1:0] new_ik_info,
	input wire [`POS_WIDTH-1:0] new_forward_i,
	input wire [`POS_WIDTH-1:0] new_min_intv,
	output wire pop,
	output wire occ_pop,
	output wire new_read,
	output logic [`STATUS_WIDTH-1:0] status_out,
	output logic [`POS_WIDTH-1:0] ptr_curr_out,
	output logic [`READ_NUM_WIDTH-1:0] read_num_out,
	output wire [`IK_WIDTH-1:0] ik_x0_out,
	output wire [`IK_WIDTH-1:0] ik_x1_out,
	output wire [`IK_WIDTH-1:0] ik_x2_out,
	output wire [`IK_WIDTH-1:0] ik_info_out,
	output logic [`POS_WIDTH-1:0] forward_i_out,
	output logic [`POS_WIDTH-1:0] min_intv_out,
	output logic [`POS_WIDTH-1:0] backward_x_out,
	output logic [`BASE_WIDTH-1:0] query_out
);

	logic [`STATUS_WIDTH-1:0] head_status;
	logic take_break;
	logic take_pair;
	logic take_new;

	// kept bits of the interval words
	logic [`IK_KEPT_WIDTH-1:0] ik_x0_kept, ik_x1_kept, ik_x2_kept;
	logic [`INFO_SLICE_WIDTH-1:0] info_hi_kept, info_lo_kept;

	// ====================
	// decision in priority order
	assign head_status = head_entry[OFS_STATUS +: `STATUS_WIDTH];
	assign take_break = head_valid && (head_status == F_BREAK);
	assign take_pair = head_valid && occ_valid
		&& ((head_status == F_RUN) || (head_status == F_INIT));
	assign take_new = !occ_valid && new_read_valid;  // a waiting response blocks new reads

	assign pop = !stall && (take_break || take_pair);
	assign occ_pop = !stall && !take_break && take_pair;
	assign new_read = reset_n && !stall && !take_break && !take_pair && take_new;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			status_out <= ST_BUBBLE;
		end else if (pop) begin
			status_out <= head_status;
		end else if (new_read) begin
			status_out <= F_INIT;
		end else if (!stall) begin
			status_out <= ST_BUBBLE;  // nothing to send
		end
	end

	// ====================
	// payload held on bubbles
	always_ff @(posedge Clk_32UI) begin
		if (pop) begin
			ptr_curr_out <= head_entry[OFS_PTR_CURR +: `POS_WIDTH];
			read_num_out <= head_entry[OFS_READ_NUM +: `READ_NUM_WIDTH];
			ik_x0_kept <= head_entry[OFS_IK_X0 +: `IK_KEPT_WIDTH];
			ik_x1_kept <= head_entry[OFS_IK_X1 +: `IK_KEPT_WIDTH];
			ik_x2_kept <= head_entry[OFS_IK_X2 +: `IK_KEPT_WIDTH];
			info_hi_kept <= head_entry[OFS_INFO_HI +: `INFO_SLICE_WIDTH];
			info_lo_kept <= head_entry[OFS_INFO_LO +: `INFO_SLICE_WIDTH];
			forward_i_out <= head_entry[OFS_FORWARD_I +: `POS_WIDTH];
			min_intv_out <= head_entry[OFS_MIN_INTV +: `POS_WIDTH];
			backward_x_out <= head_entry[OFS_BACKWARD_X +: `POS_WIDTH];
			query_out <= head_entry[OFS_QUERY +: `BASE_WIDTH];
		end else if (new_read) begin
			ptr_curr_out <= '0;
			read_num_out <= new_read_num;
			ik_x0_kept <= new_ik_x0[`IK_KEPT_WIDTH-1:0];
			ik_x1_kept <= new_ik_x1[`IK_KEPT_WIDTH-1:0];
			ik_x2_kept <= new_ik_x2[`IK_KEPT_WIDTH-1:0];
			info_hi_kept <= new_ik_info[`INFO_HI_LSB +: `INFO_SLICE_WIDTH];
			info_lo_kept <= new_ik_info[0 +: `INFO_SLICE_WIDTH];
			forward_i_out <= new_forward_i + 1'b1;
			min_intv_out <= new_min_intv;
			backward_x_out <= new_forward_i;
			query_out <= '0;  // first round has no query base
		end
	end

	// unkept bits stay zero
	assign ik_x0_out = {{(`IK_WIDTH - `IK_KEPT_WIDTH){1'b0}}, ik_x0_kept};
	assign ik_x1_out = {{(`IK_WIDTH - `IK_KEPT_WIDTH){1'b0}}, ik_x1_kept};
	assign ik_x2_out = {{(`IK_WIDTH - `IK_KEPT_WIDTH){1'b0}}, ik_x2_kept};
	assign ik_info_out = {{(`IK_WIDTH - `INFO_HI_LSB - `INFO_SLICE_WIDTH){1'b0}}, info_hi_kept,
		{(`INFO_HI_LSB - `INFO_SLICE_WIDTH){1'b0}}, info_lo_kept};

endmodule

`default_nettype wire

/* src/bwt_queue_top.sv */
// forward read queue of the seed-extension accelerator
`timescale 1ns/1ps
`default_nettype none
`include "bwt_queue_cfg.svh"

module bwt_queue_top
	import queue_entry_pkg::*;
(
	input wire Clk_32UI,
	input wire reset_n,
	input wire stall,
	// DRAM occupancy responses
	input wire DRAM_get,
	input wire [`CNT_WIDTH-1:0] cnt_a0, cnt_a1, cnt_a2, cnt_a3,
	input wire [`CNT_WIDTH-1:0] cntl_a0, cntl_a1, cntl_a2, cntl_a3,
	output wire [`CNT_WIDTH-1:0] cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out,
	output wire [`CNT_WIDTH-1:0] cntl_a0_out, cntl_a1_out, cntl_a2_out, cntl_a3_out,
	// forward pipeline in
	input wire [`STATUS_WIDTH-1:0] status,
	input wire [`POS_WIDTH-1:0] ptr_curr,
	input wire [`READ_NUM_WIDTH-1:0] read_num,
	input wire [`IK_WIDTH-1:0] ik_x0, ik_x1, ik_x2, ik_info,
	input wire [`POS_WIDTH-1:0] forward_i, min_intv, backward_x,
	// query fetch
	input wire [`POS_WIDTH-1:0] next_query_position,
	input wire [`READ_NUM_WIDTH-1:0] read_num_query,
	input wire [`STATUS_WIDTH-1:0] status_query,
	output wire [`POS_WIDTH-1:0] query_position_2RAM,
	output wire [`READ_NUM_WIDTH-1:0] query_read_num_2RAM,
	output wire [`STATUS_WIDTH-1:0] query_status_2RAM,
	input wire [`BASE_WIDTH-1:0] new_read_query_2Queue,
	// forward pipeline out
	output wire [`STATUS_WIDTH-1:0] status_out,
	output wire [`POS_WIDTH-1:0] ptr_curr_out,
	output wire [`READ_NUM_WIDTH-1:0] read_num_out,
	output wire [`IK_WIDTH-1:0] ik_x0_out, ik_x1_out, ik_x2_out, ik_info_out,
	output wire [`POS_WIDTH-1:0] forward_i_out, min_intv_out, backward_x_out,
	output wire [`BASE_WIDTH-1:0] query_out,
	// new read fetch
	output wire new_read,
	input wire new_read_valid,
	input wire [`READ_NUM_WIDTH-1:0] new_read_num,
	input wire [`IK_WIDTH-1:0] new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info,
	input wire [`POS_WIDTH-1:0] new_forward_i, new_min_intv
);

	wire [ENTRY_WIDTH-1:0] entry, head_entry;
	wire entry_write, head_valid, pop, occ_valid, occ_pop;

	assign query_position_2RAM = next_query_position;
	assign query_read_num_2RAM = read_num_query;
	assign query_status_2RAM = status_query;

	query_delay_line u_delay (.Clk_32UI, .stall, .status, .ptr_curr, .read_num, .ik_x0, .ik_x1,
		.ik_x2, .ik_info, .forward_i, .min_intv, .backward_x, .new_read_query_2Queue,
		.entry, .entry_write);

	read_queue u_read_queue (.Clk_32UI, .reset_n, .entry, .entry_write, .pop, .head_entry,
		.head_valid);

	occ_buffer u_occ (.Clk_32UI, .reset_n, .DRAM_get, .cnt_a0, .cnt_a1, .cnt_a2, .cnt_a3,
		.cntl_a0, .cntl_a1, .cntl_a2, .cntl_a3, .occ_pop, .occ_valid, .cnt_a0_out, .cnt_a1_out,
		.cnt_a2_out, .cnt_a3_out, .cntl_a0_out, .cntl_a1_out, .cntl_a2_out, .cntl_a3_out);

	queue_dispatch u_dispatch (.Clk_32UI, .reset_n, .stall, .head_entry, .head_valid,
		.occ_valid, .new_read_valid, .new_read_num, .new_ik_x0, .new_ik_x1, .new_ik_x2,
		.new_ik_info, .new_forward_i, .new_min_intv, .pop, .occ_pop, .new_read, .status_out,
		.ptr_curr_out, .read_num_out, .ik_x0_out, .ik_x1_out, .ik_x2_out, .ik_info_out,
		.forward_i_out, .min_intv_out, .backward_x_out, .query_out);

endmodule

`default_nettype wire

/* dv/tb_bwt_model.sv */
// reference queues and output checks for the forward read queue testbench
`timescale 1ns/1ps
`default_nettype none
`include "bwt_queue_cfg.svh"

module tb_bwt_model
	import queue_status_pkg::*;
#(
	parameter int OUT_W = `STATUS_WIDTH + `READ_NUM_WIDTH + 4 * `IK_WIDTH + 4 * `POS_WIDTH
		+ `BASE_WIDTH,
	parameter int FETCH_W = `POS_WIDTH + `READ_NUM_WIDTH + `STATUS_WIDTH
) (
	input wire Clk_32UI,
	input wire reset_n,
	input wire stall,
	input wire DRAM_get,
	input wire new_read,
	input wire [`READ_NUM_WIDTH-1:0] new_read_num,
	input wire [`IK_WIDTH-1:0] new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info,
	input wire [`POS_WIDTH-1:0] new_forward_i, new_min_intv,
	input wire [OUT_W-1:0] out_vec,  // status first, query last
	input wire [8*`CNT_WIDTH-1:0] cnt_vec,
	input wire [FETCH_W-1:0] fetch_in,  // position, read number, status
	input wire [FETCH_W-1:0] fetch_out,
	output logic error_seen
);

	localparam logic [`IK_WIDTH-1:0] KEEP = {{(`IK_WIDTH - `IK_KEPT_WIDTH){1'b0}},
		{`IK_KEPT_WIDTH{1'b1}}};
	localparam logic [`IK_WIDTH-1:0] INFO_KEEP = 64'h0000_007f_0000_007f;
	localparam logic [`POS_WIDTH-1:0] POS_ONE = 1;

	logic [OUT_W-1:0] exp_items [$];
	logic [8*`CNT_WIDTH-1:0] exp_resp [$];
	logic [OUT_W-1:0] held_vec, nr_vec, want;
	logic [8*`CNT_WIDTH-1:0] want_cnt;
	logic [`STATUS_WIDTH-1:0] st;
	logic prev_stall, prev_new_read, get_pending;
	int resp_count;

	initial error_seen = 1'b0;

	task automatic expect_item(input logic [OUT_W-1:0] v);
		exp_items.push_back(v);
	endtask

	task automatic expect_response(input logic [8*`CNT_WIDTH-1:0] c);
		exp_resp.push_back(c);
	endtask

	function automatic logic is_drained();
		return (exp_items.size() == 0) && (exp_resp.size() == 0);
	endfunction

	task automatic flag_error(input string msg);
		if (!error_seen) $display("[ERROR] %0t ns: %s", $time, msg);
		error_seen = 1'b1;
	endtask

	// ====================
	// outputs are stable at the falling edge
	always @(negedge Clk_32UI) begin
		st = out_vec[OUT_W-1 -: `STATUS_WIDTH];
		assert (fetch_out === fetch_in)
			else flag_error("query fetch outputs differ from the query inputs");
		if (!reset_n) begin
			assert (st == ST_BUBBLE) else flag_error("status_out is not a bubble in reset");
			assert (!new_read) else flag_error("new_read high in reset");
			prev_stall = 1'b1;  // reset edge changes no payload
			prev_new_read = 1'b0;
			get_pending = 1'b0;
			resp_count = 0;
		end else begin
			if (get_pending) resp_count++;
			if (prev_stall) begin
				assert (out_vec === held_vec) else flag_error("outputs moved under stall");
			end else if (prev_new_read) begin
				assert (out_vec === nr_vec) else flag_error("new read outputs wrong");
			end else if (st != ST_BUBBLE) begin
				if (exp_items.size() == 0) begin
					flag_error("item on status_out with none expected");
				end else begin
					want = exp_items.pop_front();
					assert (out_vec === want) else flag_error("forward item outputs wrong");
					if (st == F_RUN || st == F_INIT) begin
						if (exp_resp.size() == 0) begin
							flag_error("item paired without a response");
						end else begin
							want_cnt = exp_resp.pop_front();
							assert (cnt_vec === want_cnt) else flag_error("paired counts wrong");
						end
						resp_count--;
					end
				end
			end
			assert (!(stall && new_read)) else flag_error("new_read high under stall");
			assert (!(new_read && resp_count > 0))
				else flag_error("new read launched while a response waits");
			// expected new read from the launch rules
			nr_vec = {F_INIT, {`POS_WIDTH{1'b0}}, new_read_num, new_ik_x0 & KEEP,
				new_ik_x1 & KEEP, new_ik_x2 & KEEP, new_ik_info & INFO_KEEP,
				new_forward_i + POS_ONE, new_min_intv, new_forward_i, {`BASE_WIDTH{1'b0}}};
			prev_stall = stall;
			prev_new_read = new_read;
			get_pending = DRAM_get;
		end
		held_vec = out_vec;
	end

endmodule

`default_nettype wire

/* dv/tb_bwt_queue.sv */
// testbench for the forward read queue, stimulus and run control
`timescale 1ns/1ps
`default_nettype none
`include "bwt_queue_cfg.svh"

module tb_bwt_queue
	import queue_status_pkg::*;
;

	localparam int OUT_W = `STATUS_WIDTH + `READ_NUM_WIDTH + 4 * `IK_WIDTH + 4 * `POS_WIDTH
		+ `BASE_WIDTH;
	localparam int RAW_W = OUT_W - `BASE_WIDTH;
	localparam int NR_W = `READ_NUM_WIDTH + 4 * `IK_WIDTH + 2 * `POS_WIDTH;
	localparam int FETCH_W = `POS_WIDTH + `READ_NUM_WIDTH + `STATUS_WIDTH;
	localparam logic [`IK_WIDTH-1:0] KEEP = {{(`IK_WIDTH - `IK_KEPT_WIDTH){1'b0}},
		{`IK_KEPT_WIDTH{1'b1}}};
	localparam logic [`IK_WIDTH-1:0] INFO_KEEP = 64'h0000_007f_0000_007f;
	localparam int NR_LIMIT = 40;
	localparam int DRAIN_LIMIT = 400;

	logic Clk_32UI, reset_n, stall, DRAM_get, new_read_valid;
	logic [`CNT_WIDTH-1:0] cnt_a0, cnt_a1, cnt_a2, cnt_a3, cntl_a0, cntl_a1, cntl_a2, cntl_a3;
	wire [`CNT_WIDTH-1:0] cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out;
	wire [`CNT_WIDTH-1:0] cntl_a0_out, cntl_a1_out, cntl_a2_out, cntl_a3_out;
	logic [`STATUS_WIDTH-1:0] status, status_query;
	logic [`POS_WIDTH-1:0] ptr_curr, forward_i, min_intv, backward_x, next_query_position;
	logic [`READ_NUM_WIDTH-1:0] read_num, read_num_query, new_read_num;
	logic [`IK_WIDTH-1:0] ik_x0, ik_x1, ik_x2, ik_info;
	logic [`IK_WIDTH-1:0] new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info;
	logic [`POS_WIDTH-1:0] new_forward_i, new_min_intv;
	logic [`BASE_WIDTH-1:0] new_read_query_2Queue;
	wire [`POS_WIDTH-1:0] query_position_2RAM, ptr_curr_out, forward_i_out;
	wire [`POS_WIDTH-1:0] min_intv_out, backward_x_out;
	wire [`READ_NUM_WIDTH-1:0] query_read_num_2RAM, read_num_out;
	wire [`STATUS_WIDTH-1:0] query_status_2RAM, status_out;
	wire [`IK_WIDTH-1:0] ik_x0_out, ik_x1_out, ik_x2_out, ik_info_out;
	wire [`BASE_WIDTH-1:0] query_out;
	wire new_read, error_seen;

	logic [31:0] seed = 32'hf7ac_fda7;
	logic [RAW_W-1:0] it_raw;  // item inputs with status on top
	logic [OUT_W-1:0] it_exp;
	logic [NR_W-1:0] nr_raw;
	logic [8*`CNT_WIDTH-1:0] resp_vec;
	logic nr_valid, timeout_hit;
	logic [OUT_W-1:0] pend_vec [$];  // items still waiting for their query base
	int pend_cnt [$];

	bwt_queue_top uut (.*);

	tb_bwt_model u_model (.Clk_32UI, .reset_n, .stall, .DRAM_get, .new_read, .new_read_num,
		.new_ik_x0, .new_ik_x1, .new_ik_x2, .new_ik_info, .new_forward_i, .new_min_intv,
		.out_vec({status_out, ptr_curr_out, read_num_out, ik_x0_out, ik_x1_out, ik_x2_out,
			ik_info_out, forward_i_out, min_intv_out, backward_x_out, query_out}),
		.cnt_vec({cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out,
			cntl_a0_out, cntl_a1_out, cntl_a2_out, cntl_a3_out}),
		.fetch_in({next_query_position, read_num_query, status_query}),
		.fetch_out({query_position_2RAM, query_read_num_2RAM, query_status_2RAM}),
		.error_seen);

	always #50 Clk_32UI = ~Clk_32UI;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	always @(posedge error_seen) abort_run("a testbench check failed");
	always @(posedge timeout_hit) abort_run("timeout while waiting on the DUT");

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [63:0] rand64();
		return {next_rand(), next_rand()};
	endfunction

	// ====================
	// one clock cycle of stimulus
	task automatic step(input logic stall_v, input logic item_v, input logic resp_v);
		logic [31:0] r;
		logic [31:0] q;
		logic [OUT_W-1:0] v;
		int i;
		@(posedge Clk_32UI);
		r = next_rand();
		q = next_rand();
		if (!stall_v) begin
			i = 0;
			while (i < pend_cnt.size()) begin
				if (pend_cnt[i] == 2) begin  // base sampled at the coming edge
					v = pend_vec[i];
					v[`BASE_WIDTH-1:0] = r[`BASE_WIDTH-1:0];
					u_model.expect_item(v);
					pend_vec.delete(i);
					pend_cnt.delete(i);
				end else begin
					pend_cnt[i]++;
					i++;
				end
			end
			if (item_v) begin
				pend_vec.push_back(it_exp);
				pend_cnt.push_back(0);
			end
		end
		stall <= stall_v;
		new_read_query_2Queue <= r[`BASE_WIDTH-1:0];
		{next_query_position, read_num_query, status_query} <= q[FETCH_W-1:0];
		{status, ptr_curr, read_num, ik_x0, ik_x1, ik_x2, ik_info, forward_i, min_intv,
			backward_x} <= item_v ? it_raw : {ST_BUBBLE, it_raw[RAW_W-`STATUS_WIDTH-1:0]};
		DRAM_get <= resp_v;
		{cnt_a0, cnt_a1, cnt_a2, cnt_a3, cntl_a0, cntl_a1, cntl_a2, cntl_a3} <= resp_vec;
		new_read_valid <= nr_valid;
		{new_read_num, new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info, new_forward_i,
			new_min_intv} <= nr_raw;
	endtask

	task automatic send_item(input logic [`STATUS_WIDTH-1:0] st);
		logic [31:0] r, r2;
		logic [`IK_WIDTH-1:0] x0, x1, x2, info;
		r = next_rand();
		r2 = next_rand();
		x0 = rand64();
		x1 = rand64();
		x2 = rand64();
		info = rand64();
		it_raw = {st, r[6:0], r[12:7], x0, x1, x2, info, r[19:13], r[26:20], r2[6:0]};
		it_exp = {st, r[6:0], r[12:7], x0 & KEEP, x1 & KEEP, x2 & KEEP, info & INFO_KEEP,
			r[19:13], r[26:20], r2[6:0], {`BASE_WIDTH{1'b0}}};
		step(1'b0, 1'b1, 1'b0);
	endtask

	task automatic send_response(input logic stall_v);
		resp_vec = {rand64(), rand64(), rand64(), rand64()};
		u_model.expect_response(resp_vec);
		step(stall_v, 1'b0, 1'b1);
	endtask

	task automatic stall_for(input int n);
		repeat (n) step(1'b1, 1'b0, 1'b0);
	endtask

	task automatic arm_new_read();
		logic [31:0] r;
		r = next_rand();
		nr_raw = {r[5:0], rand64(), rand64(), rand64(), rand64(), r[12:6], r[19:13]};
		nr_valid = 1'b1;
	endtask

	task automatic wait_new_read();
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < NR_LIMIT) begin
			step(1'b0, 1'b0, 1'b0);
			@(negedge Clk_32UI);
			seen = new_read;
			n++;
		end
		nr_valid = 1'b0;
		if (!seen) timeout_hit = 1'b1;
	endtask

	initial begin
		int owed, n;
		logic [31:0] r;
		Clk_32UI = 1'b0;
		timeout_hit = 1'b0;
		nr_valid = 1'b1;  // request held high through reset
		it_raw = '0;
		nr_raw = '0;
		resp_vec = '0;
		reset_n <= 1'b0;
		stall <= 1'b0;
		DRAM_get <= 1'b0;
		new_read_valid <= 1'b1;
		{status, ptr_curr, read_num, ik_x0, ik_x1, ik_x2, ik_info, forward_i, min_intv,
			backward_x} <= {ST_BUBBLE, {(RAW_W-`STATUS_WIDTH){1'b0}}};
		{cnt_a0, cnt_a1, cnt_a2, cnt_a3, cntl_a0, cntl_a1, cntl_a2, cntl_a3} <= '0;
		{new_read_num, new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info, new_forward_i,
			new_min_intv} <= '0;
		next_query_position <= '0;
		read_num_query <= '0;
		status_query <= '0;
		new_read_query_2Queue <= '0;
		repeat (3) @(posedge Clk_32UI);
		nr_valid = 1'b0;
		step(1'b0, 1'b0, 1'b0);
		reset_n <= 1'b1;  // released after four reset edges
		repeat (3) step(1'b0, 1'b0, 1'b0);

		// ====================
		// directed cases
		arm_new_read();
		wait_new_read();
		arm_new_read();
		stall_for(3);  // armed request waits out the stall
		wait_new_read();
		repeat (3) send_item(F_BREAK);
		repeat (10) step(1'b0, 1'b0, 1'b0);
		send_item(F_RUN);
		repeat (8) step(1'b0, 1'b0, 1'b0);
		send_response(1'b0);
		repeat (4) step(1'b0, 1'b0, 1'b0);
		send_response(1'b0);  // break leaves before the pair and the new read
		arm_new_read();
		send_item(F_BREAK);
		send_item(F_RUN);
		wait_new_read();

		// ====================
		// random mix with stalls
		owed = 0;
		repeat (80) begin
			r = next_rand();
			case (r[2:0])
				3'd0, 3'd1: send_item(F_BREAK);
				3'd2: begin
					send_item(F_RUN);
					owed++;
				end
				3'd3: begin
					send_item(F_INIT);
					owed++;
				end
				3'd4: if (owed > 0) begin
					send_response(r[5]);  // DRAM writes go on under stall
					owed--;
				end
				3'd5: stall_for(int'(r[4:3]) + 1);
				default: step(1'b0, 1'b0, 1'b0);
			endcase
		end
		while (owed > 0) begin
			send_response(1'b0);
			owed--;
		end
		n = 0;
		while ((pend_vec.size() != 0 || !u_model.is_drained()) && n < DRAIN_LIMIT) begin
			step(1'b0, 1'b0, 1'b0);
			n++;
		end
		step(1'b0, 1'b0, 1'b0);
		@(negedge Clk_32UI);
		if (n == DRAIN_LIMIT || error_seen || timeout_hit) begin
			abort_run("expected items or responses were left over");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* bwt_queue.f */
+incdir+include
src/queue_status_pkg.sv
src/queue_entry_pkg.sv
src/query_delay_line.sv
src/read_queue.sv
src/occ_buffer.sv
src/queue_dispatch.sv
src/bwt_queue_top.sv
dv/tb_bwt_model.sv
dv/tb_bwt_queue.sv

/* run_sim.sh */
#!/bin/sh
# build and run the forward read queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bwt_queue \
	-f bwt_queue.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with an error status"
	exit 1
fi

if echo "$sim_out" | grep -q "^SIMULATION PASSED$"; then
	exit 0
fi
echo "pass message not found"
exit 1
